//--- common/monitor_cfg_pkg.sv
// Timing and widths assume the 8.4 MHz product clock; brightness is a 4-bit step value
package monitor_cfg_pkg;

    // ADC request spacing of about 5 ms at the product clock
    localparam int unsigned ADC_INTERVAL_DEFAULT = 41946;

    localparam int DEBOUNCE_LEN = 16;          // Button history depth
    localparam int AVG_LOG2     = 8;           // 256 samples per voltage

    localparam int BRIGHT_W = 4;
    localparam logic [BRIGHT_W-1:0] BRIGHT_RESET = 4'd3;
    localparam logic [BRIGHT_W-1:0] BRIGHT_MAX   = 4'd15;

    // Duty threshold is brightness times 16 on a 256 cycle period
    localparam int PWM_W     = 8;
    localparam int PWM_SHIFT = 4;

    typedef enum logic {
        game_mode,
        menu_mode
    } menu_mode_t;

endpackage

//--- common/battery_pkg.sv
// Thresholds are raw 14-bit ADC codes for the board's divider; chemistry comes from a strap
package battery_pkg;

    localparam int ADC_W = 14;

    typedef logic [ADC_W-1:0] volt_t;

    typedef enum logic {
        chem_aa,
        chem_lithium
    } chem_t;

    // Below this no battery is assumed, about 1.8 V
    localparam volt_t VOLT_VALID = 14'd700;

    // Low-battery warning levels
    localparam volt_t RED_AA = 14'd1071;       // About 2.8 V
    localparam volt_t RED_LI = 14'd1182;       // About 3.1 V

    localparam volt_t FULL_LI = 14'd1423;      // Charge complete, about 3.75 V

    // Backlight blanking on AA cells uses a wide hysteresis band
    localparam volt_t LOWPOWER_ENTER = 14'd979;
    localparam volt_t LOWPOWER_EXIT  = 14'd1293;

endpackage

//--- front_panel/key_debounce.sv
// One button; an event needs depth-1 stable samples, so fast chatter gives no event at all
`timescale 1ns/100ps

module key_debounce #(
    parameter int depth = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic line,
    output logic level,
    output logic rose,
    output logic fell
);

    logic             sync_1;
    logic             sync_2;
    logic [depth-1:0] history;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_1  <= 1'b0;
            sync_2  <= 1'b0;
            history <= '0;
        end else begin
            sync_1  <= line;
            sync_2  <= sync_1;
            history <= {history[depth-2:0], sync_2};   // Oldest sample in top bit
        end
    end

    assign level = sync_2;

    // One old sample of the other level, then a full run of the new one
    assign rose = (history == {1'b0, {(depth - 1){1'b1}}});
    assign fell = (history == {1'b1, {(depth - 1){1'b0}}});

endmodule

//--- front_panel/front_panel.sv
// Menu button is active low, all others active high; a tap is cancelled by any other button
`timescale 1ns/100ps

module front_panel (
    input  logic clk,
    input  logic reset,
    input  logic btn_menu_n,
    input  logic btn_left,
    input  logic btn_right,
    input  logic btn_a,
    input  logic btn_b,
    input  logic btn_up,
    input  logic btn_down,
    input  logic btn_sel,
    input  logic btn_start,
    output logic menu_disabled,
    output logic step_up,
    output logic step_down
);

    logic [5:0] other_s1;
    logic [5:0] other_s2;

    logic menu_level;
    logic menu_rose;
    logic menu_fell;
    logic left_level;
    logic left_fell;
    logic right_level;
    logic right_fell;

    logic                    menu_held;
    logic                    other_pressed;
    monitor_cfg_pkg::menu_mode_t mode;

    key_debounce #(.depth(monitor_cfg_pkg::DEBOUNCE_LEN)) menu_deb_i (
        .clk   (clk),
        .reset (reset),
        .line  (btn_menu_n),
        .level (menu_level),
        .rose  (menu_rose),
        .fell  (menu_fell)
    );

    key_debounce #(.depth(monitor_cfg_pkg::DEBOUNCE_LEN)) left_deb_i (
        .clk   (clk),
        .reset (reset),
        .line  (btn_left),
        .level (left_level),
        .rose  (),
        .fell  (left_fell)
    );

    key_debounce #(.depth(monitor_cfg_pkg::DEBOUNCE_LEN)) right_deb_i (
        .clk   (clk),
        .reset (reset),
        .line  (btn_right),
        .level (right_level),
        .rose  (),
        .fell  (right_fell)
    );

    assign other_pressed = (|other_s2) | left_level | right_level;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            other_s1  <= '0;
            other_s2  <= '0;
            menu_held <= 1'b0;
            mode      <= monitor_cfg_pkg::game_mode;
        end else begin
            other_s1 <= {btn_a, btn_b, btn_up, btn_down, btn_sel, btn_start};
            other_s2 <= other_s1;
            if (other_pressed) begin
                menu_held <= 1'b0;                 // Used as a chord, not a tap
            end else if (menu_fell) begin
                menu_held <= 1'b1;
            end else if (menu_rose && menu_held) begin
                menu_held <= 1'b0;
                mode      <= (mode == monitor_cfg_pkg::game_mode) ?
                             monitor_cfg_pkg::menu_mode : monitor_cfg_pkg::game_mode;
            end
        end
    end

    assign menu_disabled = (mode == monitor_cfg_pkg::game_mode);

    // Steps act on release, and not while menu is being held
    assign step_up   = right_fell && menu_disabled && menu_level;
    assign step_down = left_fell && menu_disabled && menu_level;

endmodule

//--- backlight/backlight_control.sv
// Blanking applies to AA cells only; the PWM period is fixed at 256 clock cycles
`timescale 1ns/100ps

module backlight_control (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  step_up,
    input  logic                                  step_down,
    input  logic                                  volt_valid,
    input  logic                                  bat_lithium,
    input  logic                                  lcd_init_done,
    input  logic                                  half_second_tick,
    input  battery_pkg::volt_t                    volt,
    output logic [monitor_cfg_pkg::BRIGHT_W-1:0] brightness,
    output logic                                  low_power_backlight,
    output logic                                  lcd_pwm
);

    logic [monitor_cfg_pkg::BRIGHT_W-1:0] saved;
    logic [monitor_cfg_pkg::PWM_W-1:0]    pwm_cnt;
    logic [monitor_cfg_pkg::PWM_W-1:0]    duty;
    logic                                 restore;
    logic                                 released;
    logic                                 enter_low;
    logic                                 exit_low;
    battery_pkg::chem_t                   chem;

    assign chem = bat_lithium ? battery_pkg::chem_lithium : battery_pkg::chem_aa;

    assign enter_low = volt_valid && (chem == battery_pkg::chem_aa) &&
                       !low_power_backlight && (volt < battery_pkg::LOWPOWER_ENTER);
    assign exit_low  = volt_valid && (chem == battery_pkg::chem_aa) &&
                       low_power_backlight && (volt > battery_pkg::LOWPOWER_EXIT);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            brightness          <= monitor_cfg_pkg::BRIGHT_RESET;
            low_power_backlight <= 1'b0;
            restore             <= 1'b0;
            released            <= 1'b0;
            pwm_cnt             <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
            restore <= 1'b0;
            if (half_second_tick) begin
                released <= 1'b1;                  // Panel has settled
            end
            if (step_down && brightness != '0) begin
                brightness <= brightness - 1'b1;
            end
            if (step_up && brightness < monitor_cfg_pkg::BRIGHT_MAX) begin
                brightness <= brightness + 1'b1;
            end
            if (low_power_backlight) begin
                brightness <= '0;                  // Overrides any step
            end
            // Saved level comes back the cycle after the flag drops
            if (restore) begin
                brightness <= saved;
            end
            if (enter_low) begin
                low_power_backlight <= 1'b1;
            end
            if (exit_low) begin
                low_power_backlight <= 1'b0;
                restore             <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enter_low) begin
            saved <= brightness;
        end
    end

    assign duty    = {brightness, {monitor_cfg_pkg::PWM_SHIFT{1'b0}}};
    assign lcd_pwm = lcd_init_done && released && (pwm_cnt <= duty);

endmodule

//--- battery/battery_monitor.sv
// Every adc_ready pulse counts as a sample; readings below VOLT_VALID mean no battery
`timescale 1ns/100ps

module battery_monitor #(
    parameter int unsigned adc_interval = monitor_cfg_pkg::ADC_INTERVAL_DEFAULT
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               adc_ready,
    input  logic               bat_lithium,
    input  logic               charging,
    input  logic               second_tick,
    input  battery_pkg::volt_t adc_value,
    output logic               adc_req,
    output battery_pkg::volt_t volt,
    output logic               volt_valid,
    output logic               low_battery,
    output logic               led_red,
    output logic               led_white
);

    localparam int TMR_W = $clog2(adc_interval + 1);

    logic [TMR_W-1:0]                                        adc_timer;
    logic [battery_pkg::ADC_W+monitor_cfg_pkg::AVG_LOG2-1:0] volt_sum;
    logic [monitor_cfg_pkg::AVG_LOG2:0]                      volt_cnt;
    logic                                                    blink;
    logic                                                    low_now;
    battery_pkg::chem_t                                      chem;
    battery_pkg::volt_t                                      red_level;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            adc_timer <= '0;
            adc_req   <= 1'b0;
        end else if (adc_timer != TMR_W'(adc_interval)) begin
            adc_timer <= adc_timer + 1'b1;
            adc_req   <= 1'b0;
        end else begin
            adc_timer <= '0;
            adc_req   <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            volt_sum <= '0;
            volt_cnt <= '0;
            volt     <= '0;
        end else begin
            if (adc_ready) begin
                volt_sum <= volt_sum + {{monitor_cfg_pkg::AVG_LOG2{1'b0}}, adc_value};
                volt_cnt <= volt_cnt + 1'b1;
            end
            // Full count wins over a sample in the same cycle
            if (volt_cnt[monitor_cfg_pkg::AVG_LOG2]) begin
                volt     <= volt_sum[$high(volt_sum):monitor_cfg_pkg::AVG_LOG2];
                volt_sum <= '0;
                volt_cnt <= '0;
            end
        end
    end

    assign volt_valid = (volt >= battery_pkg::VOLT_VALID);
    assign chem       = bat_lithium ? battery_pkg::chem_lithium : battery_pkg::chem_aa;
    assign red_level  = (chem == battery_pkg::chem_lithium) ? battery_pkg::RED_LI :
                        battery_pkg::RED_AA;
    assign low_now    = volt_valid && !charging && (volt < red_level);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            blink       <= 1'b0;
            low_battery <= 1'b0;
            led_red     <= 1'b0;
            led_white   <= 1'b0;
        end else begin
            if (second_tick) begin
                blink <= ~blink;
            end
            low_battery <= low_now;
            led_red     <= low_now && blink;
            led_white   <= volt_valid && charging && (chem == battery_pkg::chem_lithium) &&
                           (volt < battery_pkg::FULL_LI);   // Lithium still charging
        end
    end

endmodule

//--- source/system_monitor.sv
// Ticks must be one-cycle enables; adc_value is only sampled in a cycle with adc_ready
`timescale 1ns/100ps

module system_monitor #(
    parameter int unsigned adc_interval = monitor_cfg_pkg::ADC_INTERVAL_DEFAULT
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  btn_a,
    input  logic                                  btn_b,
    input  logic                                  btn_up,
    input  logic                                  btn_down,
    input  logic                                  btn_left,
    input  logic                                  btn_right,
    input  logic                                  btn_sel,
    input  logic                                  btn_start,
    input  logic                                  btn_menu_n,
    input  logic                                  lcd_init_done,
    input  logic                                  half_second_tick,
    input  logic                                  second_tick,
    input  logic                                  adc_ready,
    input  battery_pkg::volt_t                    adc_value,
    input  logic                                  bat_lithium,
    input  logic                                  charging,
    output logic                                  menu_disabled,
    output logic                                  adc_req,
    output logic                                  lcd_pwm,
    output logic [monitor_cfg_pkg::BRIGHT_W-1:0] brightness,
    output battery_pkg::volt_t                    volt,
    output logic                                  low_power_backlight,
    output logic                                  low_battery,
    output logic                                  led_red,
    output logic                                  led_white
);

    logic step_up;
    logic step_down;
    logic volt_valid;

    front_panel front_panel_i (
        .clk           (clk),
        .reset         (reset),
        .btn_menu_n    (btn_menu_n),
        .btn_left      (btn_left),
        .btn_right     (btn_right),
        .btn_a         (btn_a),
        .btn_b         (btn_b),
        .btn_up        (btn_up),
        .btn_down      (btn_down),
        .btn_sel       (btn_sel),
        .btn_start     (btn_start),
        .menu_disabled (menu_disabled),
        .step_up       (step_up),
        .step_down     (step_down)
    );

    backlight_control backlight_control_i (
        .clk                 (clk),
        .reset               (reset),
        .step_up             (step_up),
        .step_down           (step_down),
        .volt_valid          (volt_valid),
        .bat_lithium         (bat_lithium),
        .lcd_init_done       (lcd_init_done),
        .half_second_tick    (half_second_tick),
        .volt                (volt),
        .brightness          (brightness),
        .low_power_backlight (low_power_backlight),
        .lcd_pwm             (lcd_pwm)
    );

    battery_monitor #(.adc_interval(adc_interval)) battery_monitor_i (
        .clk         (clk),
        .reset       (reset),
        .adc_ready   (adc_ready),
        .bat_lithium (bat_lithium),
        .charging    (charging),
        .second_tick (second_tick),
        .adc_value   (adc_value),
        .adc_req     (adc_req),
        .volt        (volt),
        .volt_valid  (volt_valid),
        .low_battery (low_battery),
        .led_red     (led_red),
        .led_white   (led_white)
    );

endmodule

//--- verif/system_monitor_asserts.sv
// Bound to system_monitor; checks are disabled while reset is high
`timescale 1ns/100ps

module system_monitor_asserts (
    input logic       clk,
    input logic       reset,
    input logic       adc_req,
    input logic       led_red,
    input logic       low_battery,
    input logic       low_power_backlight,
    input logic [3:0] brightness
);

    req_single: assert property (@(posedge clk) disable iff (reset) adc_req |=> !adc_req)
        else $error("adc_req held for two cycles");

    red_needs_low: assert property (@(posedge clk) disable iff (reset) led_red |-> low_battery)
        else $error("led_red set without low_battery");

    blank_dark: assert property (@(posedge clk) disable iff (reset)
        low_power_backlight |=> (brightness == 4'd0))
        else $error("brightness not 0 while backlight blanked");

endmodule

bind system_monitor system_monitor_asserts asserts_i (
    .clk                 (clk),
    .reset               (reset),
    .adc_req             (adc_req),
    .led_red             (led_red),
    .low_battery         (low_battery),
    .low_power_backlight (low_power_backlight),
    .brightness          (brightness)
);

//--- verif/system_monitor_tb.sv
// ADC interval is 20 here; one voltage load takes 256 samples of 21 cycles
`timescale 1ns/100ps

module system_monitor_tb;

    localparam int CLK_NS       = 20;
    localparam int ADC_INTERVAL = 20;
    localparam int LOAD_CYCLES  = 256 * (ADC_INTERVAL + 1);
    localparam int KEY_CYCLES   = 40;
    // 16 loads are waited on, plus button sequences
    localparam longint WATCHDOG_NS = longint'((18 * LOAD_CYCLES + 8000) * CLK_NS);

    logic clk;
    logic reset;
    logic btn_a, btn_b, btn_up, btn_down, btn_left, btn_right, btn_sel, btn_start;
    logic btn_menu_n;
    logic lcd_init_done, half_second_tick, second_tick;
    logic adc_ready;
    logic [13:0] adc_value;
    logic bat_lithium, charging;
    logic menu_disabled, adc_req, lcd_pwm, low_power_backlight;
    logic low_battery, led_red, led_white;
    logic [3:0] brightness;
    logic [13:0] volt;

    logic [2:0] req_pipe;
    logic [31:0] lcg_state;
    int adc_level;
    bit use_lcg;
    int model_sum;
    int model_cnt;
    int load_count;
    int req_gap;
    logic [13:0] exp_volt;
    int exp_bright;
    bit exp_blink;
    int errors;
    int tests;
    int failed_tests;
    int test_start_err;
    string cur_test;

    system_monitor #(.adc_interval(ADC_INTERVAL)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [13:0] mean_of(input int sum);
        return 14'(sum / 256);                     // Truncated mean
    endfunction

    // Expected {low_battery, led_red, led_white}
    function automatic logic [2:0] expect_ind(input int v, input bit li, input bit chg,
                                              input bit blink);
        bit valid;
        bit low;
        int red;
        valid = v >= int'(battery_pkg::VOLT_VALID);
        red   = li ? int'(battery_pkg::RED_LI) : int'(battery_pkg::RED_AA);
        low   = valid && !chg && (v < red);
        return {low, low && blink, valid && chg && li && (v < int'(battery_pkg::FULL_LI))};
    endfunction

    // ADC model, ready three cycles after each request
    always @(negedge clk) begin
        adc_ready = 1'b0;
        if (req_pipe[2]) begin
            adc_ready = 1'b1;
            if (use_lcg) begin
                lcg_state = lcg_next(lcg_state);
                adc_value = 14'(700 + int'(lcg_state[31:16]) % 801);
            end else begin
                adc_value = 14'(adc_level);
            end
        end
        req_pipe = {req_pipe[1:0], adc_req};
    end

    // Requests repeat every interval plus one cycles
    always @(negedge clk) begin
        if (adc_req) begin
            if (req_gap != 0) begin
                check("adc_req spacing", ADC_INTERVAL + 1, req_gap);
            end
            req_gap = 1;
        end else if (req_gap != 0) begin
            req_gap++;
        end
    end

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            model_sum = 0;
            model_cnt = 0;
        end else if (adc_ready) begin
            model_sum = model_sum + int'(adc_value);
            model_cnt = model_cnt + 1;
            if (model_cnt == 256) begin
                exp_volt   <= mean_of(model_sum);
                load_count <= load_count + 1;
                model_sum  = 0;
                model_cnt  = 0;
            end
        end
    end

    task automatic check(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("Mismatch %s %s expected %0d actual %0d", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    // Compares every voltage load with the model's mean
    always begin
        @(load_count);
        @(posedge clk);
        @(negedge clk);
        check("volt", int'(exp_volt), int'(volt));
    end

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_start_err = errors;
        tests++;
    endtask

    task automatic end_test;
        if (errors == test_start_err) begin
            $display("Test %s: ok", cur_test);
        end else begin
            $display("Test %s: FAILED", cur_test);
            failed_tests++;
        end
    endtask

    task automatic wait_load;
        int start;
        start = load_count;
        wait (load_count != start);
        @(posedge clk);
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic tap_menu(input bit with_a);
        btn_menu_n = 1'b0;
        idle(10);
        btn_a = with_a;
        idle(10);
        btn_a = 1'b0;
        idle(KEY_CYCLES - 20);
        btn_menu_n = 1'b1;
        idle(KEY_CYCLES);
    endtask

    task automatic step_key(input bit up, input bit active);
        if (up) btn_right = 1'b1;
        else btn_left = 1'b1;
        idle(KEY_CYCLES);
        btn_right = 1'b0;
        btn_left  = 1'b0;
        idle(KEY_CYCLES);
        if (active && up && exp_bright < 15) exp_bright++;
        if (active && !up && exp_bright > 0) exp_bright--;
        check("brightness", exp_bright, int'(brightness));
    endtask

    task automatic check_ind;
        logic [2:0] e;
        e = expect_ind(adc_level, bat_lithium, charging, exp_blink);
        check("low_battery", int'(e[2]), int'(low_battery));
        check("led_red", int'(e[1]), int'(led_red));
        check("led_white", int'(e[0]), int'(led_white));
    endtask

    task automatic set_level(input int level);
        adc_level = level;
        wait_load;                                 // Mixed window
        wait_load;
        check("volt level", level, int'(volt));
    endtask

    task automatic lowpower_seq(input bit li);
        bat_lithium = li;
        while (exp_bright != 7) step_key(exp_bright < 7, 1'b1);
        set_level(900);
        idle(2);
        check("low_power_backlight", li ? 0 : 1, int'(low_power_backlight));
        check("brightness low", li ? 7 : 0, int'(brightness));
        set_level(1300);
        idle(3);
        check("low_power_backlight", 0, int'(low_power_backlight));
        check("brightness restored", 7, int'(brightness));
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish in time");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int high_cnt;
        reset = 1'b1;
        {btn_a, btn_b, btn_up, btn_down, btn_left, btn_right, btn_sel, btn_start} = '0;
        btn_menu_n = 1'b1;
        lcd_init_done = 1'b1;
        half_second_tick = 1'b0;
        second_tick = 1'b0;
        adc_ready = 1'b0;
        adc_value = '0;
        bat_lithium = 1'b0;
        charging = 1'b0;
        req_pipe = '0;
        lcg_state = 32'd21802;
        adc_level = 1200;
        use_lcg = 1'b0;
        load_count = 0;
        req_gap = 0;
        exp_volt = '0;
        exp_bright = 3;
        exp_blink = 1'b0;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        idle(2);

        start_test("reset");
        check("menu_disabled", 1, int'(menu_disabled));
        check("brightness", 3, int'(brightness));
        check("volt", 0, int'(volt));
        check("indicators", 0, int'({low_battery, led_red, led_white}));
        check("low_power_backlight", 0, int'(low_power_backlight));
        check("lcd_pwm", 0, int'(lcd_pwm));        // Not yet released
        end_test;

        start_test("menu_toggle");
        tap_menu(1'b0);
        check("menu tap", 0, int'(menu_disabled));
        tap_menu(1'b0);
        check("menu second tap", 1, int'(menu_disabled));
        tap_menu(1'b1);
        check("menu chord", 1, int'(menu_disabled));
        end_test;

        start_test("brightness");
        repeat (13) step_key(1'b1, 1'b1);
        step_key(1'b1, 1'b1);                      // Saturates at 15
        repeat (16) step_key(1'b0, 1'b1);
        tap_menu(1'b0);
        step_key(1'b1, 1'b0);                      // Ignored in menu mode
        tap_menu(1'b0);
        repeat (5) step_key(1'b1, 1'b1);
        half_second_tick = 1'b1;
        idle(1);
        half_second_tick = 1'b0;
        idle(2);
        high_cnt = 0;
        repeat (256) begin
            @(negedge clk);
            if (lcd_pwm) high_cnt++;
        end
        check("lcd_pwm duty", exp_bright * 16 + 1, high_cnt);
        end_test;

        start_test("averaging");
        wait_load;
        use_lcg = 1'b1;
        wait_load;
        use_lcg = 1'b0;
        check("mean", int'(exp_volt), int'(volt));
        end_test;

        start_test("battery_leds");
        set_level(1000);
        check_ind;
        repeat (3) begin
            second_tick = 1'b1;
            idle(1);
            second_tick = 1'b0;
            exp_blink = ~exp_blink;
            idle(2);
            check_ind;
        end
        charging = 1'b1;
        idle(2);
        check_ind;
        bat_lithium = 1'b1;
        set_level(1300);
        idle(1);
        check_ind;
        check("led_white on", 1, int'(led_white));
        set_level(600);
        idle(1);
        check("all off", 0, int'({low_battery, led_red, led_white}));
        charging = 1'b0;
        end_test;

        start_test("low_power_aa");
        lowpower_seq(1'b0);
        end_test;

        start_test("low_power_lithium");
        lowpower_seq(1'b1);
        end_test;

        $display("Tests run %0d, tests failed %0d, failed checks %0d",
                 tests, failed_tests, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- system_monitor.f
common/monitor_cfg_pkg.sv
common/battery_pkg.sv
front_panel/key_debounce.sv
front_panel/front_panel.sv
backlight/backlight_control.sv
battery/battery_monitor.sv
source/system_monitor.sv
verif/system_monitor_asserts.sv
verif/system_monitor_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the result
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f system_monitor.f \
    --top-module system_monitor_tb -o system_monitor_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/system_monitor_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
